// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - design/cpu_pkg.sv
  - design/register_file.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/memory_stage.sv
  - design/mips_pipeline.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_mips_pipeline.sv

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [7:0]  mem_addr_t;

    localparam int REG_COUNT      = 32;
    localparam int DATA_MEM_DEPTH = 256;

    // opcode field in instruction bits 31:26
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // funct field for r-type
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // no overflow trap so signed and unsigned add share one code
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    localparam alu_op_t ALU_LUI  = 4'd8;

    typedef struct packed {
        word_t instruction;
        logic  no_op;
    } fetch_t;

    typedef struct packed {
        logic     no_op;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        alu_op_t  alu_op;
        word_t    operand_1;
        word_t    operand_2;
        word_t    store_data;
        reg_idx_t src_1;
        reg_idx_t src_2;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed {
        logic     no_op;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::fetch_t   fetch,
    output cpu_pkg::reg_idx_t rd_idx_1,
    output cpu_pkg::reg_idx_t rd_idx_2,
    input  cpu_pkg::word_t    rd_data_1,
    input  cpu_pkg::word_t    rd_data_2,
    output logic              stall,
    output cpu_pkg::id_ex_t   id_ex
);
    import cpu_pkg::*;

    fetch_t   if_id;
    opcode_t  opcode;
    funct_t   funct;
    imm_t     imm;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    alu_op_t  alu_op;
    logic     valid_op;
    logic     is_rtype;
    logic     zero_ext;
    logic     is_load;
    logic     is_store;
    logic     live;
    logic     use_rs;
    logic     use_rt;
    word_t    imm_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id.no_op <= 1'b1;
        end else if (!stall) begin
            if_id.no_op <= fetch.no_op;
        end
        if (!stall) begin
            if_id.instruction <= fetch.instruction;
        end
    end

    assign opcode = if_id.instruction[31:26];
    assign rs     = if_id.instruction[25:21];
    assign rt     = if_id.instruction[20:16];
    assign rd     = if_id.instruction[15:11];
    assign imm    = if_id.instruction[15:0];
    assign funct  = if_id.instruction[5:0];

    always_comb begin
        valid_op = 1'b1;
        is_rtype = 1'b0;
        zero_ext = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        alu_op   = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                is_rtype = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLTU:         alu_op = ALU_SLTU;
                    default:         valid_op = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:           alu_op = ALU_SLT;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                zero_ext = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
            end
            OP_XORI: begin
                alu_op   = ALU_XOR;
                zero_ext = 1'b1;
            end
            OP_LUI:  alu_op = ALU_LUI;
            OP_LW:   is_load = 1'b1;
            OP_SW:   is_store = 1'b1;
            // anything else runs as a no-op
            default: valid_op = 1'b0;
        endcase
    end

    assign live    = valid_op && !if_id.no_op;
    assign use_rs  = live;
    assign use_rt  = live && (is_rtype || is_store);
    assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    assign rd_idx_1 = rs;
    assign rd_idx_2 = rt;

    // load in EX whose result the ID instruction needs
    assign stall = !id_ex.no_op && id_ex.mem_read && id_ex.dest != '0 &&
                   ((use_rs && id_ex.dest == rs) || (use_rt && id_ex.dest == rt));

    always_ff @(posedge clk) begin
        if (!rst_n || stall) begin
            id_ex.no_op     <= 1'b1;
            id_ex.reg_write <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
        end else begin
            id_ex.no_op     <= !live;
            id_ex.reg_write <= live && !is_store;
            id_ex.mem_read  <= live && is_load;
            id_ex.mem_write <= live && is_store;
        end
        id_ex.alu_op     <= alu_op;
        id_ex.operand_1  <= rd_data_1;
        id_ex.operand_2  <= is_rtype ? rd_data_2 : imm_ext;
        id_ex.store_data <= rd_data_2;
        id_ex.src_1      <= rs;
        // zero index keeps an immediate operand from being forwarded over
        id_ex.src_2      <= is_rtype ? rt : '0;
        // for sw this is rt, the store data source
        id_ex.dest       <= is_rtype ? rd : rt;
    end

    // the bubble after a stall clears the hazard
    assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall);

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::wb_t     wb,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t st_data;
    word_t alu_result;

    // MEM result takes priority over WB as the newer producer
    function automatic word_t forward(reg_idx_t idx, word_t decoded, ex_mem_t mem_src,
                                      wb_t wb_src);
        word_t value;
        if (idx != '0 && mem_src.reg_write && !mem_src.no_op && mem_src.dest == idx) begin
            value = mem_src.alu_result;
        end else if (idx != '0 && wb_src.valid && wb_src.dest == idx) begin
            value = wb_src.data;
        end else begin
            value = decoded;
        end
        return value;
    endfunction

    always_comb begin
        op_a    = forward(id_ex.src_1, id_ex.operand_1, ex_mem, wb);
        op_b    = forward(id_ex.src_2, id_ex.operand_2, ex_mem, wb);
        st_data = forward(id_ex.dest, id_ex.store_data, ex_mem, wb);
    end

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_NOR:  alu_result = ~(op_a | op_b);
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            // immediate into the upper half
            ALU_LUI:  alu_result = {op_b[15:0], 16'h0000};
            default:  alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.no_op     <= 1'b1;
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.no_op     <= id_ex.no_op;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
        end
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= st_data;
        ex_mem.dest       <= id_ex.dest;
    end

    // decode never marks an instruction as both load and store
    assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_mem.mem_read && ex_mem.mem_write));

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::wb_t     wb
);
    import cpu_pkg::*;

    word_t     data_mem [DATA_MEM_DEPTH];
    mem_addr_t addr;
    word_t     read_data;

    logic      wb_no_op;
    logic      wb_reg_write;
    logic      wb_mem_read;
    word_t     wb_read_data;
    word_t     wb_alu_result;
    reg_idx_t  wb_dest;

    // word address from byte address
    assign addr      = ex_mem.alu_result[9:2];
    assign read_data = data_mem[addr];

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write && !ex_mem.no_op) begin
            data_mem[addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_no_op     <= 1'b1;
            wb_reg_write <= 1'b0;
            wb_mem_read  <= 1'b0;
        end else begin
            wb_no_op     <= ex_mem.no_op;
            wb_reg_write <= ex_mem.reg_write;
            wb_mem_read  <= ex_mem.mem_read;
        end
        wb_read_data  <= read_data;
        wb_alu_result <= ex_mem.alu_result;
        wb_dest       <= ex_mem.dest;
    end

    always_comb begin
        wb.valid = !wb_no_op && wb_reg_write && wb_dest != '0;
        wb.dest  = wb_dest;
        wb.data  = wb_mem_read ? wb_read_data : wb_alu_result;
    end

endmodule

`default_nettype wire

// ==== design/mips_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_pipeline (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::fetch_t fetch,
    output logic            stall,
    output cpu_pkg::wb_t    wb
);
    import cpu_pkg::*;

    reg_idx_t rd_idx_1;
    reg_idx_t rd_idx_2;
    word_t    rd_data_1;
    word_t    rd_data_2;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;

    decode_stage i_decode_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch     (fetch),
        .rd_idx_1  (rd_idx_1),
        .rd_idx_2  (rd_idx_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .stall     (stall),
        .id_ex     (id_ex)
    );

    // write port fed back from write-back
    register_file i_register_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_1  (rd_idx_1),
        .rd_idx_2  (rd_idx_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .wb        (wb)
    );

    execute_stage i_execute_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_ex     (id_ex),
        .wb        (wb),
        .ex_mem    (ex_mem)
    );

    memory_stage i_memory_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rd_idx_1,
    input  cpu_pkg::reg_idx_t rd_idx_2,
    output cpu_pkg::word_t    rd_data_1,
    output cpu_pkg::word_t    rd_data_2,
    input  cpu_pkg::wb_t      wb
);
    import cpu_pkg::*;

    // register 0 has no storage
    word_t regs [1:REG_COUNT-1];

    function automatic word_t read_port(reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (wb.valid && wb.dest == idx) begin
            // same-cycle write goes straight through
            data = wb.data;
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

    always_comb begin
        rd_data_1 = read_port(rd_idx_1);
        rd_data_2 = read_port(rd_idx_2);
    end

    // write-back stage never reports a write to register 0
    assert property (@(posedge clk) disable iff (!rst_n) wb.valid |-> wb.dest != '0);

endmodule

`default_nettype wire

// ==== verification/tb_program_table.svh ====
`ifndef TB_PROGRAM_TABLE_SVH
`define TB_PROGRAM_TABLE_SVH

function automatic word_t r_format(funct_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t i_format(opcode_t op, reg_idx_t rt, reg_idx_t rs, imm_t imm);
    return {op, rs, rt, imm};
endfunction

task automatic writing_entry(string name, word_t instr, reg_idx_t dest, word_t data,
                             logic stall_exp);
    prog_entry_t e;
    e.name      = name;
    e.instr     = instr;
    e.no_op     = 1'b0;
    e.has_write = 1'b1;
    e.dest      = dest;
    e.data      = data;
    e.stall_exp = stall_exp;
    program_q.push_back(e);
    expected_q.push_back(e);
endtask

task automatic silent_entry(string name, word_t instr, logic no_op);
    prog_entry_t e;
    e.name      = name;
    e.instr     = instr;
    e.no_op     = no_op;
    e.has_write = 1'b0;
    e.dest      = '0;
    e.data      = '0;
    e.stall_exp = 1'b0;
    program_q.push_back(e);
endtask

// name, instruction, expected dest and value, load-use stall while in ID
task automatic build_program();
    writing_entry("addi_pos", i_format(OP_ADDI, 1, 0, 16'h0005), 1, 32'h00000005, 0);
    writing_entry("addi_neg", i_format(OP_ADDI, 2, 0, 16'hfffd), 2, 32'hfffffffd, 0);
    writing_entry("addiu_sext", i_format(OP_ADDIU, 3, 0, 16'h8000), 3, 32'hffff8000, 0);
    writing_entry("andi_zext_d2", i_format(OP_ANDI, 4, 2, 16'hff0f), 4, 32'h0000ff0d, 0);
    writing_entry("ori_zext", i_format(OP_ORI, 5, 1, 16'h8000), 5, 32'h00008005, 0);
    writing_entry("xori_d1", i_format(OP_XORI, 6, 5, 16'hffff), 6, 32'h00007ffa, 0);
    writing_entry("slti_neg", i_format(OP_SLTI, 7, 1, 16'hffff), 7, 32'h00000000, 0);
    writing_entry("lui", i_format(OP_LUI, 8, 0, 16'h1234), 8, 32'h12340000, 0);
    writing_entry("sltu_neg", r_format(FN_SLTU, 9, 1, 2), 9, 32'h00000001, 0);
    writing_entry("slt_neg", r_format(FN_SLT, 10, 1, 2), 10, 32'h00000000, 0);
    writing_entry("add", r_format(FN_ADD, 11, 1, 2), 11, 32'h00000002, 0);
    writing_entry("sub_d1", r_format(FN_SUB, 12, 11, 1), 12, 32'hfffffffd, 0);
    writing_entry("subu_d1", r_format(FN_SUBU, 13, 12, 2), 13, 32'h00000000, 0);
    writing_entry("addu_d2_d3", r_format(FN_ADDU, 14, 12, 11), 14, 32'hffffffff, 0);
    writing_entry("and_d1", r_format(FN_AND, 15, 14, 8), 15, 32'h12340000, 0);
    writing_entry("or", r_format(FN_OR, 16, 6, 1), 16, 32'h00007fff, 0);
    writing_entry("xor_d1", r_format(FN_XOR, 17, 16, 3), 17, 32'hffffffff, 0);
    writing_entry("nor_r0", r_format(FN_NOR, 18, 17, 0), 18, 32'h00000000, 0);
    silent_entry("sw_word4", i_format(OP_SW, 8, 0, 16'h0010), 0);
    writing_entry("lw_word4", i_format(OP_LW, 19, 0, 16'h0010), 19, 32'h12340000, 0);
    writing_entry("addi_store_src", i_format(OP_ADDI, 20, 0, 16'h0055), 20, 32'h00000055, 0);
    silent_entry("sw_fwd_data", i_format(OP_SW, 20, 0, 16'h0014), 0);
    writing_entry("lw_word5", i_format(OP_LW, 21, 0, 16'h0014), 21, 32'h00000055, 0);
    writing_entry("add_load_use", r_format(FN_ADD, 22, 21, 21), 22, 32'h000000aa, 1);
    silent_entry("no_op_flag", i_format(OP_ADDI, 23, 0, 16'h0007), 1);
    silent_entry("addi_r0_dest", i_format(OP_ADDI, 0, 1, 16'h0009), 0);
    writing_entry("add_r0_src", r_format(FN_ADD, 23, 0, 1), 23, 32'h00000005, 0);
    // jump opcode is outside the subset
    silent_entry("jump_opcode", {6'h02, 26'h0000123}, 0);
    writing_entry("addi_last", i_format(OP_ADDI, 25, 23, 16'h0001), 25, 32'h00000006, 0);
endtask

`endif

// ==== verification/tb_mips_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mips_pipeline;
    import cpu_pkg::*;

    typedef struct {
        string    name;
        word_t    instr;
        logic     no_op;
        logic     has_write;
        reg_idx_t dest;
        word_t    data;
        logic     stall_exp;
    } prog_entry_t;

    logic        clk = 1'b0;
    logic        rst_n;
    fetch_t      fetch;
    logic        stall;
    wb_t         wb;

    prog_entry_t program_q[$];
    prog_entry_t expected_q[$];
    prog_entry_t wb_head;
    int          cycle_count;
    int          cycle_limit;

    `include "tb_program_table.svh"

    mips_pipeline i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .fetch (fetch),
        .stall (stall),
        .wb    (wb)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_idle(input string phase);
        assert (!stall && !wb.valid)
        else fail_run($sformatf("stall or write-back active %s (stall %b, valid %b)",
                                phase, stall, wb.valid));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, write-backs still missing",
                               cycle_count));
        end
    end

    // write-backs must leave in program order
    always @(negedge clk) begin
        if (rst_n && wb.valid) begin
            assert (expected_q.size() != 0)
            else fail_run($sformatf("write-back to r%0d = %h when none was expected",
                                    wb.dest, wb.data));
            wb_head = expected_q.pop_front();
            assert (wb.dest == wb_head.dest && wb.data == wb_head.data)
            else fail_run($sformatf("[ERROR] %s: expected r%0d = %h, actual r%0d = %h",
                                    wb_head.name, wb_head.dest, wb_head.data,
                                    wb.dest, wb.data));
        end
    end

    initial begin
        int i;
        build_program();
        cycle_limit       = 2 * program_q.size() + 30;
        rst_n             = 1'b0;
        fetch.instruction = '0;
        fetch.no_op       = 1'b1;

        repeat (2) begin
            @(negedge clk);
            check_idle("during reset");
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle("right after reset");
        end

        for (i = 0; i <= program_q.size(); i++) begin
            if (i < program_q.size()) begin
                fetch.instruction = program_q[i].instr;
                fetch.no_op       = program_q[i].no_op;
            end else begin
                fetch.instruction = '0;
                fetch.no_op       = 1'b1;
            end
            // entry i-1 sits in ID now
            if (i > 0) begin
                assert (stall == program_q[i-1].stall_exp)
                else fail_run($sformatf("[ERROR] %s: expected stall %b, actual stall %b",
                                        program_q[i-1].name, program_q[i-1].stall_exp,
                                        stall));
                if (stall) begin
                    @(negedge clk);
                    assert (!stall)
                    else fail_run($sformatf("stall held longer than one cycle at %s",
                                            program_q[i-1].name));
                end
            end
            @(negedge clk);
        end

        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        // drain cycles with no further write-back expected
        repeat (4) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
design/cpu_pkg.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_pipeline.sv
verification/tb_mips_pipeline.sv
